// File: udp_rx_buffer.f
verilog/udp_net_pkg.sv
verilog/udp_buf_pkg.sv
verilog/rx_frame_fsm.sv
verilog/rx_slot_counter.sv
verilog/payload_packer.sv
verilog/buffer_writer.sv
verilog/udp_rx_buffer_top.sv
verification/udp_rx_buffer_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the UDP receive buffer testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=udp_rx_buffer_sim

verilator --binary --timing -Wno-fatal -f udp_rx_buffer.f \
    --top-module udp_rx_buffer_tb -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"
exit 0

// File: verification/udp_rx_buffer_tb.sv
/* Testbench for the UDP receive buffer with random frames from a fixed seed,
   a slot ring model, a write port monitor and a watchdog */
module udp_rx_buffer_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          BUF_LEN         = 4;
    localparam int          SLOT_BYTES      = 64;
    localparam int          MAX_PORTS       = 1024;
    localparam logic [31:0] BASE_ADDR       = 32'h1000_0000;
    localparam int          CLK_PERIOD      = 40;
    localparam int          N_RANDOM        = 40;
    localparam int          N_FRAMES        = N_RANDOM + 8;
    localparam int          WATCHDOG_CYCLES = N_FRAMES * (SLOT_BYTES + 20) * 8;

    logic        clk;
    logic        rst_n_i;
    logic        hdr_valid_i;
    logic [31:0] hdr_source_ip_i;
    logic [15:0] hdr_source_port_i;
    logic [15:0] hdr_dest_port_i;
    logic [15:0] hdr_udp_length_i;
    logic        hdr_ready_o;
    logic [7:0]  payload_tdata_i;
    logic        payload_tvalid_i;
    logic        payload_tlast_i;
    logic        payload_tready_o;
    logic [31:0] wr_addr_o;
    logic [63:0] wr_data_o;
    logic [7:0]  wr_keep_o;
    logic        wr_valid_o;
    logic        wr_ready_i;
    logic        pop_i;
    logic [2:0]  rx_pending_o;
    logic        buffer_rx_pushed_interr_o;

    integer      seed;
    int          error_count;
    int          stores;
    int          drops;
    int          irq_count;
    int          pend_exp;
    int          slot_exp;
    bit          irq_exp;
    int          pop_mode;
    logic [7:0]  pay_bytes [0:127];

    // Expected write port words and their kind (0 header, 1 payload, 2 last payload)
    logic [31:0] exp_addr[$];
    logic [63:0] exp_data[$];
    logic [7:0]  exp_keep[$];
    int          exp_kind[$];

    udp_rx_buffer_top #(
        .BUFFER_RX_LENGTH     (BUF_LEN),
        .BUFFER_ELEM_MAX_SIZE (SLOT_BYTES),
        .MAX_UDP_PORTS        (MAX_PORTS),
        .BUFFER_BASE_ADDR     (BASE_ADDR)
    ) DUT (.*);

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                   input logic [63:0] act_val);
        error_count++;
        $display("[FAIL] %s: expected %h, actual %h (at %0t)", name, exp_val, act_val, $time);
    endtask

    task automatic report_problem(input string msg);
        error_count++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    // One frame as a header handshake and then payload bytes with random gaps
    task automatic send_frame(input bit rand_fields, input int dport_in, input int plen_in);
        int dport;
        int plen;
        int i;
        bit hs;
        @(posedge clk);
        dport = dport_in;
        plen  = plen_in;
        if (rand_fields) begin
            dport = (($unsigned($random(seed)) % 8) == 0) ?
                    1024 + $unsigned($random(seed)) % 4000 : $unsigned($random(seed)) % 1024;
            plen  = 1 + $unsigned($random(seed)) % 64;
        end
        for (i = 0; i < plen; i++) begin
            pay_bytes[i] = 8'($random(seed));
        end
        hdr_valid_i       <= 1'b1;
        hdr_source_ip_i   <= 32'($random(seed));
        hdr_source_port_i <= 16'($random(seed));
        hdr_dest_port_i   <= dport[15:0];
        hdr_udp_length_i  <= plen[15:0] + 16'd8;
        hs = 1'b0;
        while (!hs) begin
            @(negedge clk);
            hs = hdr_ready_o;
            @(posedge clk);
        end
        hdr_valid_i <= 1'b0;
        i = 0;
        while (i < plen) begin
            if (($unsigned($random(seed)) % 4) == 0) begin
                payload_tvalid_i <= 1'b0;
                payload_tlast_i  <= 1'b0;
                @(posedge clk);
            end else begin
                payload_tvalid_i <= 1'b1;
                payload_tdata_i  <= pay_bytes[i];
                payload_tlast_i  <= (i == plen - 1);
                hs = 1'b0;
                while (!hs) begin
                    @(negedge clk);
                    hs = payload_tready_o;
                    @(posedge clk);
                end
                i++;
            end
        end
        payload_tvalid_i <= 1'b0;
        payload_tlast_i  <= 1'b0;
    endtask

    // Wait for the FSM to return to idle
    task automatic wait_idle();
        @(negedge clk);
        while (!hdr_ready_o) begin
            @(negedge clk);
        end
    endtask

    // Write back-pressure and host pops drawn at negedge and driven at posedge
    initial begin : bus_gaps
        bit nxt_ready;
        bit nxt_pop;
        forever begin
            @(negedge clk);
            nxt_ready = ($unsigned($random(seed)) % 4) != 0;
            nxt_pop   = 1'b0;
            if (pop_mode == 1) begin
                nxt_pop = ($unsigned($random(seed)) % 16) == 0;
            end else if (pop_mode == 2) begin
                nxt_pop  = 1'b1;
                pop_mode = 0;
            end
            @(posedge clk);
            wr_ready_i <= nxt_ready;
            pop_i      <= nxt_pop;
        end
    end

    initial begin : write_monitor
        int          plen;
        int          nwords;
        int          w;
        int          b;
        int          kind;
        logic [31:0] base;
        logic [31:0] ea;
        logic [63:0] ed;
        logic [7:0]  ek;
        logic [63:0] mask;
        bit          store_done;
        bit          pop_ok;
        bit          stall_q;
        logic [31:0] hold_addr;
        logic [63:0] hold_data;
        logic [7:0]  hold_keep;
        stall_q = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n_i) begin
                store_done = 1'b0;
                if (rx_pending_o !== pend_exp[2:0]) begin
                    report_mismatch("rx_pending", pend_exp, rx_pending_o);
                end
                if (buffer_rx_pushed_interr_o !== irq_exp) begin
                    report_mismatch("interrupt", irq_exp, buffer_rx_pushed_interr_o);
                end
                if (buffer_rx_pushed_interr_o === 1'b1) begin
                    irq_count++;
                end
                // A stalled word must stay on the port unchanged
                if (stall_q) begin
                    if (!wr_valid_o) begin
                        report_problem("write valid dropped while wr_ready_i was low");
                    end else if (wr_addr_o !== hold_addr || wr_data_o !== hold_data ||
                                 wr_keep_o !== hold_keep) begin
                        report_problem("write address, data or keep changed while stalled");
                    end
                end
                stall_q   = wr_valid_o && !wr_ready_i;
                hold_addr = wr_addr_o;
                hold_data = wr_data_o;
                hold_keep = wr_keep_o;
                // Store or drop decision on header acceptance
                if (hdr_valid_i && hdr_ready_o) begin
                    plen = int'(hdr_udp_length_i) - 8;
                    if (int'(hdr_dest_port_i) < MAX_PORTS && plen <= SLOT_BYTES - 8 &&
                        pend_exp != BUF_LEN) begin
                        base = BASE_ADDR + 32'(slot_exp * SLOT_BYTES);
                        exp_addr.push_back(base);
                        exp_data.push_back({hdr_source_ip_i, hdr_source_port_i, 16'(plen)});
                        exp_keep.push_back(8'hff);
                        exp_kind.push_back(0);
                        nwords = (plen + 7) / 8;
                        for (w = 0; w < nwords; w++) begin
                            ed = '0;
                            ek = '0;
                            for (b = 0; b < 8; b++) begin
                                if (w * 8 + b < plen) begin
                                    ed[b*8 +: 8] = pay_bytes[w*8 + b];
                                    ek[b]        = 1'b1;
                                end
                            end
                            exp_addr.push_back(base + 32'((w + 1) * 8));
                            exp_data.push_back(ed);
                            exp_keep.push_back(ek);
                            exp_kind.push_back((w == nwords - 1) ? 2 : 1);
                        end
                        slot_exp = (slot_exp + 1) % BUF_LEN;
                        stores++;
                    end else begin
                        drops++;
                    end
                end
                if (wr_valid_o && wr_ready_i) begin
                    if (exp_addr.size() == 0) begin
                        report_problem("write handshake with no expected word outstanding");
                    end else begin
                        ea   = exp_addr.pop_front();
                        ed   = exp_data.pop_front();
                        ek   = exp_keep.pop_front();
                        kind = exp_kind.pop_front();
                        for (b = 0; b < 8; b++) begin
                            mask[b*8 +: 8] = {8{ek[b]}};
                        end
                        if (wr_addr_o !== ea) begin
                            report_mismatch("write_address", ea, wr_addr_o);
                        end
                        if ((wr_data_o & mask) !== ed) begin
                            report_mismatch((kind == 0) ? "header_word" : "payload_word",
                                            ed, wr_data_o & mask);
                        end
                        if (wr_keep_o !== ek) begin
                            report_mismatch("write_keep", ek, wr_keep_o);
                        end
                        store_done = (kind == 2);
                    end
                end
                // Count and interrupt move one cycle after the event
                pop_ok   = pop_i && (pend_exp != 0);
                pend_exp = pend_exp + int'(store_done) - int'(pop_ok);
                irq_exp  = store_done;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, frames did not complete", WATCHDOG_CYCLES);
        $display("Errors: %0d, stored: %0d, dropped: %0d", error_count, stores, drops);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : main_seq
        seed              = 32'h2cbf;
        error_count       = 0;
        stores            = 0;
        drops             = 0;
        irq_count         = 0;
        pend_exp          = 0;
        slot_exp          = 0;
        irq_exp           = 1'b0;
        pop_mode          = 0;
        rst_n_i           = 1'b0;
        hdr_valid_i       = 1'b0;
        hdr_source_ip_i   = '0;
        hdr_source_port_i = '0;
        hdr_dest_port_i   = '0;
        hdr_udp_length_i  = '0;
        payload_tdata_i   = '0;
        payload_tvalid_i  = 1'b0;
        payload_tlast_i   = 1'b0;
        wr_ready_i        = 1'b0;
        pop_i             = 1'b0;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        if (hdr_ready_o !== 1'b1) report_mismatch("reset_hdr_ready", 1, hdr_ready_o);
        if (payload_tready_o !== 1'b0) report_mismatch("reset_tready", 0, payload_tready_o);
        if (wr_valid_o !== 1'b0) report_mismatch("reset_wr_valid", 0, wr_valid_o);

        // Port out of range and then a payload too long for a slot
        send_frame(1'b0, 1500, 16);
        send_frame(1'b0, 7, 60);
        wait_idle();
        if (irq_count != 0) begin
            report_mismatch("drop_interrupts", 0, irq_count);
        end

        // Fill the ring so the fifth frame finds it full
        send_frame(1'b0, 80, 5);
        send_frame(1'b0, 81, 8);
        send_frame(1'b0, 82, 13);
        send_frame(1'b0, 83, 56);
        send_frame(1'b0, 84, 20);
        wait_idle();
        if (rx_pending_o !== 3'd4) report_mismatch("ring_full_pending", 4, rx_pending_o);
        if (irq_count != 4) begin
            report_mismatch("ring_full_interrupts", 4, irq_count);
        end

        // One pop frees a slot and the next frame wraps to slot 0
        @(posedge clk);
        pop_mode = 2;
        @(negedge clk);
        while (rx_pending_o !== 3'd3) begin
            @(negedge clk);
        end
        send_frame(1'b0, 99, 24);
        wait_idle();
        if (rx_pending_o !== 3'd4) report_mismatch("pop_then_store_pending", 4, rx_pending_o);

        // Random frames with random host pops
        @(posedge clk);
        pop_mode = 1;
        repeat (N_RANDOM) send_frame(1'b1, 0, 0);
        @(posedge clk);
        pop_mode = 0;
        wait_idle();
        if (exp_addr.size() != 0) begin
            report_problem("expected write words were never seen on the write port");
        end

        $display("Errors: %0d, stored: %0d, dropped: %0d", error_count, stores, drops);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verilog/udp_rx_buffer_top.sv
/* UDP receive buffer top: frame FSM, slot counter, payload packer
   and buffer writer */
module udp_rx_buffer_top #(
    parameter int                     BUFFER_RX_LENGTH     = 32,
    parameter int                     BUFFER_ELEM_MAX_SIZE = 2048,
    parameter int                     MAX_UDP_PORTS        = 1024,
    parameter udp_buf_pkg::buf_addr_t BUFFER_BASE_ADDR     = 32'h1000_0000
) (
    input  logic                                  clk,
    input  logic                                  rst_n_i,
    input  logic                                  hdr_valid_i,
    input  udp_net_pkg::ip_addr_t                 hdr_source_ip_i,
    input  udp_net_pkg::udp_port_t                hdr_source_port_i,
    input  udp_net_pkg::udp_port_t                hdr_dest_port_i,
    input  udp_net_pkg::udp_len_t                 hdr_udp_length_i,
    output logic                                  hdr_ready_o,
    input  logic [7:0]                            payload_tdata_i,
    input  logic                                  payload_tvalid_i,
    input  logic                                  payload_tlast_i,
    output logic                                  payload_tready_o,
    output udp_buf_pkg::buf_addr_t                wr_addr_o,
    output logic [udp_buf_pkg::WORD_WIDTH-1:0]    wr_data_o,
    output udp_buf_pkg::buf_keep_t                wr_keep_o,
    output logic                                  wr_valid_o,
    input  logic                                  wr_ready_i,
    input  logic                                  pop_i,
    output logic [$clog2(BUFFER_RX_LENGTH+1)-1:0] rx_pending_o,
    output logic                                  buffer_rx_pushed_interr_o
);

    localparam int IDX_W = $clog2(BUFFER_RX_LENGTH);

    logic                   pack_en;
    logic                   pack_ready;
    logic                   full;
    logic                   slot_push;
    logic                   last_done;
    logic                   hdr_load;
    udp_buf_pkg::buf_word_u hdr_word;
    logic                   hdr_written;
    logic [IDX_W-1:0]       slot_idx;
    udp_buf_pkg::buf_addr_t slot_idx_addr;
    udp_buf_pkg::buf_word_u word;
    udp_buf_pkg::buf_keep_t keep;
    logic                   word_last;
    logic                   word_valid;
    logic                   word_ready;

    // Slot index widened for address arithmetic
    assign slot_idx_addr = udp_buf_pkg::ADDR_WIDTH'(slot_idx);

    rx_frame_fsm #(
        .MAX_UDP_PORTS        (MAX_UDP_PORTS),
        .BUFFER_ELEM_MAX_SIZE (BUFFER_ELEM_MAX_SIZE)
    ) u_rx_frame_fsm (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .hdr_valid_i       (hdr_valid_i),
        .hdr_source_ip_i   (hdr_source_ip_i),
        .hdr_source_port_i (hdr_source_port_i),
        .hdr_dest_port_i   (hdr_dest_port_i),
        .hdr_udp_length_i  (hdr_udp_length_i),
        .hdr_ready_o       (hdr_ready_o),
        .payload_tvalid_i  (payload_tvalid_i),
        .payload_tlast_i   (payload_tlast_i),
        .payload_tready_o  (payload_tready_o),
        .pack_en_o         (pack_en),
        .pack_ready_i      (pack_ready),
        .full_i            (full),
        .slot_push_o       (slot_push),
        .last_done_i       (last_done),
        .hdr_load_o        (hdr_load),
        .hdr_word_o        (hdr_word),
        .hdr_written_i     (hdr_written),
        .interr_o          (buffer_rx_pushed_interr_o)
    );

    rx_slot_counter #(
        .BUFFER_RX_LENGTH (BUFFER_RX_LENGTH)
    ) u_rx_slot_counter (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .slot_push_i (slot_push),
        .pop_i       (pop_i),
        .full_o      (full),
        .slot_idx_o  (slot_idx),
        .pending_o   (rx_pending_o)
    );

    payload_packer u_payload_packer (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .pack_en_i        (pack_en),
        .payload_tdata_i  (payload_tdata_i),
        .payload_tvalid_i (payload_tvalid_i),
        .payload_tlast_i  (payload_tlast_i),
        .payload_tready_o (pack_ready),
        .word_o           (word),
        .keep_o           (keep),
        .word_last_o      (word_last),
        .word_valid_o     (word_valid),
        .word_ready_i     (word_ready)
    );

    buffer_writer #(
        .BUFFER_BASE_ADDR     (BUFFER_BASE_ADDR),
        .BUFFER_ELEM_MAX_SIZE (BUFFER_ELEM_MAX_SIZE)
    ) u_buffer_writer (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .slot_idx_i    (slot_idx_addr),
        .hdr_load_i    (hdr_load),
        .hdr_word_i    (hdr_word),
        .hdr_written_o (hdr_written),
        .word_i        (word),
        .keep_i        (keep),
        .word_last_i   (word_last),
        .word_valid_i  (word_valid),
        .word_ready_o  (word_ready),
        .last_done_o   (last_done),
        .wr_addr_o     (wr_addr_o),
        .wr_data_o     (wr_data_o),
        .wr_keep_o     (wr_keep_o),
        .wr_valid_o    (wr_valid_o),
        .wr_ready_i    (wr_ready_i)
    );

endmodule

// File: verilog/buffer_writer.sv
/* Slot address generation and the registered memory write port
   for header and payload words */
module buffer_writer #(
    parameter udp_buf_pkg::buf_addr_t BUFFER_BASE_ADDR     = 32'h1000_0000,
    parameter int                     BUFFER_ELEM_MAX_SIZE = 2048
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  udp_buf_pkg::buf_addr_t              slot_idx_i,
    input  logic                                hdr_load_i,
    input  udp_buf_pkg::buf_word_u              hdr_word_i,
    output logic                                hdr_written_o,
    input  udp_buf_pkg::buf_word_u              word_i,
    input  udp_buf_pkg::buf_keep_t              keep_i,
    input  logic                                word_last_i,
    input  logic                                word_valid_i,
    output logic                                word_ready_o,
    output logic                                last_done_o,
    output udp_buf_pkg::buf_addr_t              wr_addr_o,
    output logic [udp_buf_pkg::WORD_WIDTH-1:0]  wr_data_o,
    output udp_buf_pkg::buf_keep_t              wr_keep_o,
    output logic                                wr_valid_o,
    input  logic                                wr_ready_i
);

    localparam udp_buf_pkg::buf_addr_t SLOT_BYTES = udp_buf_pkg::ADDR_WIDTH'(BUFFER_ELEM_MAX_SIZE);
    localparam udp_buf_pkg::buf_addr_t WORD_STEP  = udp_buf_pkg::ADDR_WIDTH'(udp_buf_pkg::WORD_BYTES);

    udp_buf_pkg::buf_addr_t slot_base;
    udp_buf_pkg::buf_addr_t next_addr_q;
    logic                   is_hdr_q;
    logic                   is_last_q;
    logic                   wr_hs;
    logic                   word_hs;

    assign slot_base = BUFFER_BASE_ADDR + slot_idx_i * SLOT_BYTES;

    assign wr_hs        = wr_valid_o && wr_ready_i;
    assign word_ready_o = !wr_valid_o || wr_ready_i;
    assign word_hs      = word_valid_i && word_ready_o;

    assign hdr_written_o = wr_hs && is_hdr_q;
    assign last_done_o   = wr_hs && !is_hdr_q && is_last_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_valid_o <= 1'b0;
            is_hdr_q   <= 1'b0;
            is_last_q  <= 1'b0;
        end else if (hdr_load_i) begin
            wr_valid_o <= 1'b1;
            is_hdr_q   <= 1'b1;
            is_last_q  <= 1'b0;
        end else if (word_hs) begin
            wr_valid_o <= 1'b1;
            is_hdr_q   <= 1'b0;
            is_last_q  <= word_last_i;
        end else if (wr_hs) begin
            wr_valid_o <= 1'b0;
        end
    end

    // Header at the slot base, payload from the next word on
    always_ff @(posedge clk) begin
        if (hdr_load_i) begin
            wr_addr_o   <= slot_base;
            wr_data_o   <= hdr_word_i.raw;
            wr_keep_o   <= '1;
            next_addr_q <= slot_base + WORD_STEP;
        end else if (word_hs) begin
            wr_addr_o   <= next_addr_q;
            wr_data_o   <= word_i.raw;
            wr_keep_o   <= keep_i;
            next_addr_q <= next_addr_q + WORD_STEP;
        end
    end

endmodule

// File: verilog/payload_packer.sv
/* Byte to word packer: little-endian lanes, keeps, and a held output word */
module payload_packer (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   pack_en_i,
    input  logic [7:0]             payload_tdata_i,
    input  logic                   payload_tvalid_i,
    input  logic                   payload_tlast_i,
    output logic                   payload_tready_o,
    output udp_buf_pkg::buf_word_u word_o,
    output udp_buf_pkg::buf_keep_t keep_o,
    output logic                   word_last_o,
    output logic                   word_valid_o,
    input  logic                   word_ready_i
);

    localparam int LANE_W = $clog2(udp_buf_pkg::KEEP_WIDTH);

    logic [udp_buf_pkg::WORD_WIDTH-1:0] acc_data_q;
    udp_buf_pkg::buf_keep_t             acc_keep_q;
    logic [LANE_W-1:0]                  lane_q;
    logic [udp_buf_pkg::WORD_WIDTH-1:0] next_data;
    udp_buf_pkg::buf_keep_t             next_keep;
    logic                               byte_hs;
    logic                               emit;

    // Input stalls while a finished word is still waiting
    assign payload_tready_o = pack_en_i && (!word_valid_o || word_ready_i);
    assign byte_hs          = payload_tvalid_i && payload_tready_o;
    assign emit             = byte_hs && (payload_tlast_i || (&lane_q));

    always_comb begin
        next_data                  = acc_data_q;
        next_data[lane_q*8 +: 8]   = payload_tdata_i;
        next_keep                  = acc_keep_q | (udp_buf_pkg::buf_keep_t'(1) << lane_q);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            acc_data_q <= '0;
            acc_keep_q <= '0;
            lane_q     <= '0;
        end else if (emit) begin
            acc_data_q <= '0;
            acc_keep_q <= '0;
            lane_q     <= '0;
        end else if (byte_hs) begin
            acc_data_q <= next_data;
            acc_keep_q <= next_keep;
            lane_q     <= lane_q + 1'b1;
        end
    end

    // Output word register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            word_valid_o <= 1'b0;
            word_last_o  <= 1'b0;
        end else if (emit) begin
            word_valid_o <= 1'b1;
            word_last_o  <= payload_tlast_i;
        end else if (word_ready_i) begin
            word_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            word_o.raw <= next_data;
            keep_o     <= next_keep;
        end
    end

endmodule

// File: verilog/rx_slot_counter.sv
/* Receive ring bookkeeping: write slot index, occupancy and full flag */
module rx_slot_counter #(
    parameter int BUFFER_RX_LENGTH = 32
) (
    input  logic                                  clk,
    input  logic                                  rst_n_i,
    input  logic                                  slot_push_i,
    input  logic                                  pop_i,
    output logic                                  full_o,
    output logic [$clog2(BUFFER_RX_LENGTH)-1:0]   slot_idx_o,
    output logic [$clog2(BUFFER_RX_LENGTH+1)-1:0] pending_o
);

    localparam int IDX_W = $clog2(BUFFER_RX_LENGTH);
    localparam int CNT_W = $clog2(BUFFER_RX_LENGTH + 1);

    logic [IDX_W-1:0] wr_idx_q;
    logic [CNT_W-1:0] count_q;
    logic             pop_valid;

    // Pop on an empty ring is ignored
    assign pop_valid = pop_i && (count_q != '0);

    assign full_o     = (count_q == CNT_W'(BUFFER_RX_LENGTH));
    assign slot_idx_o = wr_idx_q;
    assign pending_o  = count_q;

    // Write index wraps at the ring length
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_idx_q <= '0;
        end else if (slot_push_i) begin
            if (wr_idx_q == IDX_W'(BUFFER_RX_LENGTH - 1)) begin
                wr_idx_q <= '0;
            end else begin
                wr_idx_q <= wr_idx_q + 1'b1;
            end
        end
    end

    // Push and pop together cancel out
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (slot_push_i && !pop_valid) begin
            count_q <= count_q + 1'b1;
        end else if (pop_valid && !slot_push_i) begin
            count_q <= count_q - 1'b1;
        end
    end

endmodule

// File: verilog/rx_frame_fsm.sv
/* Receive frame FSM: accept/drop decision per header, then header write,
   payload and completion sequencing, or discard of a dropped payload */
module rx_frame_fsm #(
    parameter int MAX_UDP_PORTS        = 1024,
    parameter int BUFFER_ELEM_MAX_SIZE = 2048
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   hdr_valid_i,
    input  udp_net_pkg::ip_addr_t  hdr_source_ip_i,
    input  udp_net_pkg::udp_port_t hdr_source_port_i,
    input  udp_net_pkg::udp_port_t hdr_dest_port_i,
    input  udp_net_pkg::udp_len_t  hdr_udp_length_i,
    output logic                   hdr_ready_o,
    input  logic                   payload_tvalid_i,
    input  logic                   payload_tlast_i,
    output logic                   payload_tready_o,
    output logic                   pack_en_o,
    input  logic                   pack_ready_i,
    input  logic                   full_i,
    output logic                   slot_push_o,
    input  logic                   last_done_i,
    output logic                   hdr_load_o,
    output udp_buf_pkg::buf_word_u hdr_word_o,
    input  logic                   hdr_written_i,
    output logic                   interr_o
);

    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_HDR_WR  = 3'd1;
    localparam logic [2:0] ST_PAYLOAD = 3'd2;
    localparam logic [2:0] ST_DONE    = 3'd3;
    localparam logic [2:0] ST_DISCARD = 3'd4;

    // Largest payload that fits behind the header word
    localparam int MAX_PAYLOAD = BUFFER_ELEM_MAX_SIZE - udp_buf_pkg::WORD_BYTES;

    logic [2:0]            state_q;
    logic                  last_seen_q;
    udp_net_pkg::udp_len_t payload_len;
    logic                  accept;
    logic                  byte_last_hs;

    assign payload_len = hdr_udp_length_i - udp_net_pkg::LEN_WIDTH'(udp_net_pkg::UDP_HDR_BYTES);

    assign accept = (32'(hdr_dest_port_i) < MAX_UDP_PORTS) &&
                    (32'(payload_len) <= MAX_PAYLOAD) && !full_i;

    always_comb begin
        hdr_word_o.hdr.src_ip      = hdr_source_ip_i;
        hdr_word_o.hdr.src_port    = hdr_source_port_i;
        hdr_word_o.hdr.payload_len = payload_len;
    end

    assign hdr_ready_o = (state_q == ST_IDLE);
    assign hdr_load_o  = hdr_ready_o && hdr_valid_i && accept;

    // Bytes go to the packer until tlast, a drop swallows everything
    assign pack_en_o        = (state_q == ST_PAYLOAD) && !last_seen_q;
    assign payload_tready_o = (state_q == ST_DISCARD) || ((state_q == ST_PAYLOAD) && pack_ready_i);
    assign byte_last_hs     = payload_tvalid_i && payload_tready_o && payload_tlast_i;

    // Slot counted on the last write, interrupt follows a cycle later
    assign slot_push_o = (state_q == ST_PAYLOAD) && last_done_i;
    assign interr_o    = (state_q == ST_DONE);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= ST_IDLE;
            last_seen_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    last_seen_q <= 1'b0;
                    if (hdr_valid_i) begin
                        state_q <= accept ? ST_HDR_WR : ST_DISCARD;
                    end
                end
                ST_HDR_WR: begin
                    if (hdr_written_i) begin
                        state_q <= ST_PAYLOAD;
                    end
                end
                ST_PAYLOAD: begin
                    if (byte_last_hs) begin
                        last_seen_q <= 1'b1;
                    end
                    if (last_done_i) begin
                        state_q <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    state_q <= ST_IDLE;
                end
                ST_DISCARD: begin
                    if (byte_last_hs) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: verilog/udp_buf_pkg.sv
/* Host buffer word, keep and address widths, and the stored
   word union with its slot header view */
package udp_buf_pkg;

    // One buffer word is 64 bits with a keep bit per byte
    localparam int WORD_WIDTH = 64;
    localparam int KEEP_WIDTH = 8;
    localparam int WORD_BYTES = 8;

    // Host byte address
    localparam int ADDR_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0] buf_addr_t;
    typedef logic [KEEP_WIDTH-1:0] buf_keep_t;

    // Slot header word, source IP in the top bits
    typedef struct packed {
        udp_net_pkg::ip_addr_t  src_ip;
        udp_net_pkg::udp_port_t src_port;
        udp_net_pkg::udp_len_t  payload_len;
    } rx_slot_hdr_t;

    // Same stored word seen as payload bits or as a slot header
    typedef union packed {
        logic [WORD_WIDTH-1:0] raw;
        rx_slot_hdr_t          hdr;
    } buf_word_u;

endpackage

// File: verilog/udp_net_pkg.sv
/* Network field widths, UDP constants and field types
   for the receive path */
package udp_net_pkg;

    // IPv4 address
    localparam int IP_WIDTH = 32;

    // UDP port and length fields
    localparam int PORT_WIDTH = 16;
    localparam int LEN_WIDTH  = 16;

    // UDP header size; the UDP length field includes it
    localparam int UDP_HDR_BYTES = 8;

    typedef logic [IP_WIDTH-1:0]   ip_addr_t;
    typedef logic [PORT_WIDTH-1:0] udp_port_t;
    typedef logic [LEN_WIDTH-1:0]  udp_len_t;

endpackage
